// ==== branch_unit.f ====
verilog/bpred_pkg.sv
verilog/branch_decode.sv
verilog/branch_predictor.sv
verilog/branch_resolve.sv
verilog/branch_tracker.sv
verilog/branch_unit.sv
tb/branch_unit_sva.sv
tb/tb_branch_unit.sv

// ==== Makefile ====
# Verilator build and run of the branch statistics unit testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_branch_unit
FILELIST  ?= branch_unit.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

// ==== tb/tb_branch_unit.sv ====
// Testbench that runs a directed table and a random mix on branch_unit against a reference model
`default_nettype none

module tb_branch_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHT_BITS    = bpred_pkg::DEF_PHT_BITS;
    localparam int COUNT_W     = 32;
    localparam int NUM_STIM    = 32;
    localparam int NUM_RANDOM  = 300;
    localparam int DRAIN_LIMIT = 8;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // One table row with the outcome worked out from the branch rules
    typedef struct packed {
        bpred_pkg::branch_op_t op;
        logic                  neg;
        logic [31:0]           pc;
        logic [31:0]           rs1;
        logic [31:0]           rs2;
        logic                  taken;
        logic [3:0]            idle;
    } stim_t;

    // Model view of an instruction in flight
    typedef struct packed {
        logic                valid;
        logic                uncond;
        logic [PHT_BITS-1:0] index;
        logic                backward;
        logic                predicted;
        logic                taken;
    } entry_t;

    localparam stim_t IDLE = '0;

    localparam stim_t STIM_TABLE [NUM_STIM] = '{
        // Each condition with equal, signed negative and unsigned large operands
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h104, 32'd5,         32'd5,         1'b1, 4'd0},
        '{bpred_pkg::OP_BEQ,  1'b1, 32'h108, 32'hffff_ffff, 32'h1,         1'b0, 4'd0},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h10c, 32'h1,         32'h8000_0000, 1'b0, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b0, 32'h110, 32'd5,         32'd5,         1'b0, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b1, 32'h114, 32'hffff_ffff, 32'h1,         1'b1, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b0, 32'h118, 32'h1,         32'h8000_0000, 1'b1, 4'd0},
        '{bpred_pkg::OP_BLT,  1'b0, 32'h11c, 32'd5,         32'd5,         1'b0, 4'd0},
        '{bpred_pkg::OP_BLT,  1'b1, 32'h120, 32'hffff_ffff, 32'h1,         1'b1, 4'd0},
        '{bpred_pkg::OP_BLT,  1'b0, 32'h124, 32'h1,         32'h8000_0000, 1'b0, 4'd0},
        '{bpred_pkg::OP_BGE,  1'b0, 32'h128, 32'd5,         32'd5,         1'b1, 4'd0},
        '{bpred_pkg::OP_BGE,  1'b1, 32'h12c, 32'hffff_ffff, 32'h1,         1'b0, 4'd0},
        '{bpred_pkg::OP_BGE,  1'b0, 32'h130, 32'h1,         32'h8000_0000, 1'b1, 4'd0},
        '{bpred_pkg::OP_BLTU, 1'b0, 32'h134, 32'd5,         32'd5,         1'b0, 4'd0},
        '{bpred_pkg::OP_BLTU, 1'b1, 32'h138, 32'hffff_ffff, 32'h1,         1'b0, 4'd0},
        '{bpred_pkg::OP_BLTU, 1'b0, 32'h13c, 32'h1,         32'h8000_0000, 1'b1, 4'd0},
        '{bpred_pkg::OP_BGEU, 1'b0, 32'h140, 32'd5,         32'd5,         1'b1, 4'd0},
        '{bpred_pkg::OP_BGEU, 1'b1, 32'h144, 32'hffff_ffff, 32'h1,         1'b1, 4'd0},
        '{bpred_pkg::OP_BGEU, 1'b0, 32'h148, 32'h1,         32'h8000_0000, 1'b0, 4'd0},
        // Same taken branch three cycles apart
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1f0, 32'd7,         32'd7,         1'b1, 4'd2},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1f0, 32'd7,         32'd7,         1'b1, 4'd2},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1f0, 32'd7,         32'd7,         1'b1, 4'd2},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1f0, 32'd7,         32'd7,         1'b1, 4'd2},
        // Back to back inside the training hazard window
        '{bpred_pkg::OP_BNE,  1'b1, 32'h1e0, 32'd1,         32'd2,         1'b1, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b1, 32'h1e0, 32'd1,         32'd2,         1'b1, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b1, 32'h1e0, 32'd1,         32'd2,         1'b1, 4'd0},
        '{bpred_pkg::OP_BNE,  1'b1, 32'h1e0, 32'd1,         32'd2,         1'b1, 4'd0},
        // Jumps on fresh entries, then branches late enough to see any jump training
        '{bpred_pkg::OP_JAL,  1'b1, 32'h1d0, 32'd0,         32'd0,         1'b1, 4'd0},
        '{bpred_pkg::OP_JALR, 1'b1, 32'h1c0, 32'd0,         32'd0,         1'b1, 4'd2},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1d0, 32'd3,         32'd4,         1'b0, 4'd0},
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1c0, 32'd3,         32'd4,         1'b0, 4'd0},
        // Wrong guess on a trained entry and a non-branch
        '{bpred_pkg::OP_BEQ,  1'b0, 32'h1f0, 32'd3,         32'd4,         1'b0, 4'd0},
        '{bpred_pkg::OP_NONE, 1'b0, 32'h1e0, 32'd9,         32'd9,         1'b0, 4'd2}
    };

    logic                CLK = 1'b0;
    logic                nRST;
    logic                instr_valid;
    logic [31:0]         instr;
    logic [31:0]         pc;
    logic [31:0]         rs1_data;
    logic [31:0]         rs2_data;
    bpred_pkg::stat_id_t stat_sel;
    logic                mispredict;
    logic [COUNT_W-1:0]  stat_value;

    logic [1:0]          model_pht [2**PHT_BITS];
    logic [31:0]         model_cnt [16];
    entry_t              pipe [3];
    logic                mp_q [$];

    always #5 CLK = ~CLK;

    branch_unit #(.PHT_BITS(PHT_BITS), .COUNT_W(COUNT_W)) dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .stat_sel    (stat_sel),
        .mispredict  (mispredict),
        .stat_value  (stat_value)
    );

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] encode(input bpred_pkg::branch_op_t op, input logic neg);
        logic [31:0] w;
        w     = '0;
        w[31] = neg;
        case (op)
            bpred_pkg::OP_BEQ:  w[14:0] = {3'b000, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_BNE:  w[14:0] = {3'b001, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_BLT:  w[14:0] = {3'b100, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_BGE:  w[14:0] = {3'b101, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_BLTU: w[14:0] = {3'b110, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_BGEU: w[14:0] = {3'b111, 5'd0, OPC_BRANCH};
            bpred_pkg::OP_JAL:  w[14:0] = {3'b000, 5'd1, 7'b1101111};
            bpred_pkg::OP_JALR: w[14:0] = {3'b000, 5'd1, 7'b1100111};
            // ADDI stands in for any non-branch
            default:            w[14:0] = {3'b000, 5'd1, 7'b0010011};
        endcase
        return w;
    endfunction

    function automatic logic branch_taken(input bpred_pkg::branch_op_t op,
                                          input logic [31:0] a, input logic [31:0] b);
        case (op)
            bpred_pkg::OP_BEQ:  return a == b;
            bpred_pkg::OP_BNE:  return a != b;
            bpred_pkg::OP_BLT:  return $signed(a) < $signed(b);
            bpred_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            bpred_pkg::OP_BLTU: return a < b;
            bpred_pkg::OP_BGEU: return a >= b;
            bpred_pkg::OP_JAL:  return 1'b1;
            bpred_pkg::OP_JALR: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 3))
            0:       return 32'd5;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic bump(input bpred_pkg::stat_id_t id, input logic cond);
        if (cond) begin
            model_cnt[id] = model_cnt[id] + 32'd1;
        end
    endtask

    // Statistics and training of an instruction whose third edge has come
    task automatic retire(input entry_t e);
        logic ok;
        ok = (e.predicted == e.taken);
        bump(bpred_pkg::ST_UNCOND, e.valid && e.uncond);
        if (e.valid && !e.uncond) begin
            bump(bpred_pkg::ST_PRED, 1'b1);
            bump(bpred_pkg::ST_CORRECT, ok);
            bump(bpred_pkg::ST_MISPRED, !ok);
            bump(bpred_pkg::ST_PRED_TAKEN, e.predicted);
            bump(bpred_pkg::ST_PRED_NOT_TAKEN, !e.predicted);
            bump(bpred_pkg::ST_TAKEN_WRONG, e.predicted && !e.taken);
            bump(bpred_pkg::ST_NOT_TAKEN_WRONG, !e.predicted && e.taken);
            bump(bpred_pkg::ST_FWD, !e.backward);
            bump(bpred_pkg::ST_FWD_PRED_TAKEN, !e.backward && e.predicted);
            bump(bpred_pkg::ST_FWD_TAKEN_OK, !e.backward && e.predicted && e.taken);
            bump(bpred_pkg::ST_FWD_NOT_TAKEN_OK, !e.backward && ok && !e.taken);
            bump(bpred_pkg::ST_BWD, e.backward);
            bump(bpred_pkg::ST_BWD_PRED_TAKEN, e.backward && e.predicted);
            bump(bpred_pkg::ST_BWD_TAKEN_OK, e.backward && e.predicted && e.taken);
            bump(bpred_pkg::ST_BWD_NOT_TAKEN_OK, e.backward && ok && !e.taken);
            if (e.taken && model_pht[e.index] != 2'b11) begin
                model_pht[e.index] = model_pht[e.index] + 2'd1;
            end else if (!e.taken && model_pht[e.index] != 2'b00) begin
                model_pht[e.index] = model_pht[e.index] - 2'd1;
            end
        end
    endtask

    // Drive one instruction or bubble for a cycle and check mispredict two cycles later
    task automatic issue(input stim_t s, input logic valid);
        entry_t m;
        @(posedge CLK);
        retire(pipe[2]);
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        m           = '0;
        m.valid     = valid && (s.op != bpred_pkg::OP_NONE);
        m.uncond    = (s.op == bpred_pkg::OP_JAL) || (s.op == bpred_pkg::OP_JALR);
        m.index     = s.pc[2 +: PHT_BITS];
        m.backward  = (s.op != bpred_pkg::OP_JALR) && s.neg;
        m.predicted = model_pht[m.index][1];
        m.taken     = s.taken;
        pipe[0]     = m;
        mp_q.push_back(m.valid && !m.uncond && (m.predicted != m.taken));
        instr_valid <= valid;
        instr       <= encode(s.op, s.neg);
        pc          <= s.pc;
        rs1_data    <= s.rs1;
        rs2_data    <= s.rs2;
        @(negedge CLK);
        check_eq(32'(mispredict), 32'(mp_q.pop_front()), "mispredict");
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pipe[0].valid || pipe[1].valid || pipe[2].valid) begin
            if (waited >= DRAIN_LIMIT) begin
                $display("Timeout: pipeline did not drain at %0t", $time);
                $display("** FAIL **");
                $fatal(1, "drain timeout");
            end else begin
                issue(IDLE, 1'b0);
                waited++;
            end
        end
    endtask

    task automatic sweep_stats();
        for (int i = 0; i < 16; i++) begin
            @(posedge CLK);
            stat_sel <= bpred_pkg::stat_id_t'(4'(i));
            @(negedge CLK);
            check_eq(stat_value, model_cnt[i], $sformatf("statistic %0d", i));
        end
    endtask

    initial begin
        stim_t rnd;
        void'($urandom(18987));
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        stat_sel    = bpred_pkg::ST_UNCOND;
        for (int i = 0; i < 2**PHT_BITS; i++) begin
            model_pht[i] = 2'b01;
        end
        for (int i = 0; i < 16; i++) begin
            model_cnt[i] = '0;
        end
        pipe[0] = '0;
        pipe[1] = '0;
        pipe[2] = '0;
        // Mispredict is low for the two cycles before the first issue reaches it
        mp_q.push_back(1'b0);
        mp_q.push_back(1'b0);
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        sweep_stats();

        for (int n = 0; n < NUM_STIM; n++) begin
            issue(STIM_TABLE[n], 1'b1);
            repeat (STIM_TABLE[n].idle) issue(IDLE, 1'b0);
        end
        drain();
        sweep_stats();

        // Random mix on a few PHT entries at one instruction per cycle
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd.op    = bpred_pkg::branch_op_t'(4'($urandom_range(0, 8)));
            rnd.neg   = ($urandom_range(0, 1) == 1);
            rnd.pc    = 32'h200 + ($urandom_range(0, 7) << 2);
            rnd.rs1   = pick_operand();
            rnd.rs2   = pick_operand();
            rnd.taken = branch_taken(rnd.op, rnd.rs1, rnd.rs2);
            rnd.idle  = '0;
            issue(rnd, 1'b1);
        end
        drain();
        sweep_stats();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/branch_unit_sva.sv ====
// Concurrent checks on the statistic counters, bound into every branch_tracker instance
`default_nettype none

module branch_unit_sva #(
    parameter int COUNT_W = 32
) (
    input logic               CLK,
    input logic               nRST,
    input logic [COUNT_W-1:0] counters [16]
);
    timeunit 1ns;
    timeprecision 1ps;

    logic all_zero;

    always_comb begin
        all_zero = 1'b1;
        for (int i = 0; i < 16; i++) begin
            if (counters[i] != '0) begin
                all_zero = 1'b0;
            end
        end
    end

    // Every conditional branch is either forward or backward
    a_dir_split: assert property (@(posedge CLK) disable iff (!nRST)
        counters[bpred_pkg::ST_PRED] == counters[bpred_pkg::ST_FWD] + counters[bpred_pkg::ST_BWD])
        else $error("ST_PRED differs from ST_FWD plus ST_BWD");

    a_pred_split: assert property (@(posedge CLK) disable iff (!nRST)
        counters[bpred_pkg::ST_PRED] ==
            counters[bpred_pkg::ST_PRED_TAKEN] + counters[bpred_pkg::ST_PRED_NOT_TAKEN])
        else $error("ST_PRED differs from taken plus not-taken predictions");

    a_outcome_split: assert property (@(posedge CLK) disable iff (!nRST)
        counters[bpred_pkg::ST_PRED] ==
            counters[bpred_pkg::ST_CORRECT] + counters[bpred_pkg::ST_MISPRED])
        else $error("ST_PRED differs from ST_CORRECT plus ST_MISPRED");

    a_reset_clear: assert property (@(posedge CLK) !nRST |=> all_zero)
        else $error("Statistic counters not cleared after reset");

endmodule

bind branch_tracker branch_unit_sva #(.COUNT_W(COUNT_W)) u_sva (
    .CLK      (CLK),
    .nRST     (nRST),
    .counters (counters)
);

`default_nettype wire

// ==== verilog/branch_unit.sv ====
// Top level of the branch statistics unit, connecting decode, predictor, resolve and tracker
`default_nettype none

module branch_unit #(
    parameter int PHT_BITS = bpred_pkg::DEF_PHT_BITS,
    parameter int COUNT_W  = bpred_pkg::DEF_COUNT_W
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    input  logic [31:0]         rs1_data,
    input  logic [31:0]         rs2_data,
    input  bpred_pkg::stat_id_t stat_sel,
    output logic                mispredict,
    output logic [COUNT_W-1:0]  stat_value
);

    logic                predicted;
    bpred_pkg::decode_t  dec;
    bpred_pkg::resolve_t res;

    // Lookup for the incoming PC
    branch_predictor #(.PHT_BITS(PHT_BITS)) u_predictor (
        .CLK       (CLK),
        .nRST      (nRST),
        .pc        (pc),
        .res       (res),
        .predicted (predicted)
    );

    branch_decode #(.PHT_BITS(PHT_BITS)) u_decode (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .predicted   (predicted),
        .dec         (dec)
    );

    branch_resolve u_resolve (
        .CLK        (CLK),
        .nRST       (nRST),
        .dec        (dec),
        .res        (res),
        .mispredict (mispredict)
    );

    branch_tracker #(.COUNT_W(COUNT_W)) u_tracker (
        .CLK        (CLK),
        .nRST       (nRST),
        .res        (res),
        .stat_sel   (stat_sel),
        .stat_value (stat_value)
    );

endmodule

`default_nettype wire

// ==== verilog/branch_tracker.sv ====
// Branch prediction performance counters updated from the resolve stage, read through stat_sel
`default_nettype none

module branch_tracker #(
    parameter int COUNT_W = bpred_pkg::DEF_COUNT_W
) (
    input  logic                CLK,
    input  logic                nRST,
    input  bpred_pkg::resolve_t res,
    input  bpred_pkg::stat_id_t stat_sel,
    output logic [COUNT_W-1:0]  stat_value
);

    localparam int NUM_STATS = 16;

    logic [COUNT_W-1:0]   counters [NUM_STATS];
    logic [NUM_STATS-1:0] inc;
    logic                 pred;
    logic                 taken;
    logic                 correct;

    assign pred    = res.predicted;
    assign taken   = res.taken;
    assign correct = (pred == taken);

    // One increment flag per statistic
    always_comb begin
        inc = '0;
        if (res.valid) begin
            if (res.uncond) begin
                inc[bpred_pkg::ST_UNCOND] = 1'b1;
            end else begin
                inc[bpred_pkg::ST_PRED]            = 1'b1;
                inc[bpred_pkg::ST_CORRECT]         = correct;
                inc[bpred_pkg::ST_MISPRED]         = !correct;
                inc[bpred_pkg::ST_PRED_TAKEN]      = pred;
                inc[bpred_pkg::ST_PRED_NOT_TAKEN]  = !pred;
                inc[bpred_pkg::ST_TAKEN_WRONG]     = pred && !taken;
                inc[bpred_pkg::ST_NOT_TAKEN_WRONG] = !pred && taken;
                // Direction split follows the immediate sign
                if (res.backward) begin
                    inc[bpred_pkg::ST_BWD]              = 1'b1;
                    inc[bpred_pkg::ST_BWD_PRED_TAKEN]   = pred;
                    inc[bpred_pkg::ST_BWD_TAKEN_OK]     = pred && taken;
                    inc[bpred_pkg::ST_BWD_NOT_TAKEN_OK] = !pred && !taken;
                end else begin
                    inc[bpred_pkg::ST_FWD]              = 1'b1;
                    inc[bpred_pkg::ST_FWD_PRED_TAKEN]   = pred;
                    inc[bpred_pkg::ST_FWD_TAKEN_OK]     = pred && taken;
                    inc[bpred_pkg::ST_FWD_NOT_TAKEN_OK] = !pred && !taken;
                end
            end
        end
    end

    // Counters wrap at the top of their range
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_STATS; i++) begin
                counters[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_STATS; i++) begin
                if (inc[i]) begin
                    counters[i] <= counters[i] + 1'b1;
                end
            end
        end
    end

    assign stat_value = counters[stat_sel];

endmodule

`default_nettype wire

// ==== verilog/branch_resolve.sv ====
// Resolve stage that evaluates the branch condition and flags a wrong prediction for one cycle
`default_nettype none

module branch_resolve (
    input  logic                CLK,
    input  logic                nRST,
    input  bpred_pkg::decode_t  dec,
    output bpred_pkg::resolve_t res,
    output logic                mispredict
);

    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                taken;
    logic                uncond;
    bpred_pkg::resolve_t res_next;

    assign eq   = (dec.rs1 == dec.rs2);
    assign lt_s = ($signed(dec.rs1) < $signed(dec.rs2));
    assign lt_u = (dec.rs1 < dec.rs2);

    assign uncond = (dec.op == bpred_pkg::OP_JAL) || (dec.op == bpred_pkg::OP_JALR);

    always_comb begin
        case (dec.op)
            bpred_pkg::OP_BEQ:  taken = eq;
            bpred_pkg::OP_BNE:  taken = !eq;
            bpred_pkg::OP_BLT:  taken = lt_s;
            bpred_pkg::OP_BGE:  taken = !lt_s;
            bpred_pkg::OP_BLTU: taken = lt_u;
            bpred_pkg::OP_BGEU: taken = !lt_u;
            // Jumps always redirect
            bpred_pkg::OP_JAL:  taken = 1'b1;
            bpred_pkg::OP_JALR: taken = 1'b1;
            default:            taken = 1'b0;
        endcase
    end

    always_comb begin
        res_next           = '0;
        res_next.valid     = dec.valid;
        res_next.uncond    = uncond;
        res_next.index     = dec.index;
        res_next.backward  = dec.backward;
        res_next.predicted = dec.predicted;
        res_next.taken     = taken;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res        <= '0;
            mispredict <= 1'b0;
        end else begin
            res        <= res_next;
            // Jumps are never predicted so they cannot mispredict
            mispredict <= dec.valid && !uncond && (dec.predicted != taken);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
// Pattern history table of 2-bit saturating counters, looked up by PC and trained at resolve
`default_nettype none

module branch_predictor #(
    parameter int PHT_BITS = bpred_pkg::DEF_PHT_BITS
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [31:0]         pc,
    input  bpred_pkg::resolve_t res,
    output logic                predicted
);

    localparam int ENTRIES = 2 ** PHT_BITS;

    // Counter encoding 00 strong NT, 01 weak NT, 10 weak T, 11 strong T
    localparam logic [1:0] WEAK_NOT_TAKEN = 2'b01;

    logic [1:0]          pht [ENTRIES];
    logic [PHT_BITS-1:0] rd_idx;
    logic [PHT_BITS-1:0] wr_idx;
    logic                train;
    logic [1:0]          cur_cnt;
    logic [1:0]          next_cnt;

    // Lookup is combinational so decode can register the prediction
    assign rd_idx    = pc[2 +: PHT_BITS];
    assign predicted = pht[rd_idx][1];

    // Only conditional branches train the table
    assign train   = res.valid && !res.uncond;
    assign wr_idx  = res.index[PHT_BITS-1:0];
    assign cur_cnt = pht[wr_idx];

    always_comb begin
        next_cnt = cur_cnt;
        if (res.taken) begin
            if (cur_cnt != 2'b11) begin
                next_cnt = cur_cnt + 2'd1;
            end
        end else begin
            if (cur_cnt != 2'b00) begin
                next_cnt = cur_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= WEAK_NOT_TAKEN;
            end
        end else if (train) begin
            pht[wr_idx] <= next_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_decode.sv ====
// Decode stage that picks out branches and jumps and registers them with their prediction
`default_nettype none

module branch_decode #(
    parameter int PHT_BITS = bpred_pkg::DEF_PHT_BITS
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    input  logic [31:0]        pc,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    input  logic               predicted,
    output bpred_pkg::decode_t dec
);

    // RV32I major opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    bpred_pkg::branch_op_t op;
    bpred_pkg::decode_t    dec_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        op = bpred_pkg::OP_NONE;
        case (opcode)
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = bpred_pkg::OP_BEQ;
                    3'b001:  op = bpred_pkg::OP_BNE;
                    3'b100:  op = bpred_pkg::OP_BLT;
                    3'b101:  op = bpred_pkg::OP_BGE;
                    3'b110:  op = bpred_pkg::OP_BLTU;
                    3'b111:  op = bpred_pkg::OP_BGEU;
                    default: op = bpred_pkg::OP_NONE;
                endcase
            end
            OPC_JAL:  op = bpred_pkg::OP_JAL;
            OPC_JALR: op = (funct3 == 3'b000) ? bpred_pkg::OP_JALR : bpred_pkg::OP_NONE;
            default:  op = bpred_pkg::OP_NONE;
        endcase
    end

    always_comb begin
        dec_next       = '0;
        // Anything that is not a branch or jump becomes a bubble
        dec_next.valid = instr_valid && (op != bpred_pkg::OP_NONE);
        dec_next.op    = op;
        dec_next.index[PHT_BITS-1:0] = pc[2 +: PHT_BITS];
        // Bit 31 is the immediate sign for SB and J formats, JALR counts as forward
        dec_next.backward  = (op != bpred_pkg::OP_JALR) && instr[31];
        dec_next.predicted = predicted;
        dec_next.rs1       = rs1_data;
        dec_next.rs2       = rs2_data;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bpred_pkg.sv ====
// Shared types and default sizes of the branch statistics unit, compiled before every other source
`default_nettype none

package bpred_pkg;

    // Default sizes, overridden through the top-level parameters
    localparam int DEF_PHT_BITS = 6;
    localparam int DEF_COUNT_W  = 32;

    // Stored index width keeps the stage structs a fixed size
    localparam int PHT_MAX_BITS = 10;

    typedef enum logic [3:0] {
        OP_NONE, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
        OP_BLTU, OP_BGEU, OP_JAL, OP_JALR
    } branch_op_t;

    // Order sets the stat_sel encoding of the read port
    typedef enum logic [3:0] {
        ST_UNCOND, ST_PRED, ST_MISPRED, ST_CORRECT,
        ST_PRED_TAKEN, ST_PRED_NOT_TAKEN, ST_TAKEN_WRONG, ST_NOT_TAKEN_WRONG,
        ST_FWD, ST_FWD_PRED_TAKEN, ST_FWD_TAKEN_OK, ST_FWD_NOT_TAKEN_OK,
        ST_BWD, ST_BWD_PRED_TAKEN, ST_BWD_TAKEN_OK, ST_BWD_NOT_TAKEN_OK
    } stat_id_t;

    // Decode stage register
    typedef struct packed {
        logic                    valid;
        branch_op_t              op;
        logic [PHT_MAX_BITS-1:0] index;
        logic                    backward;
        logic                    predicted;
        logic [31:0]             rs1;
        logic [31:0]             rs2;
    } decode_t;

    // Resolve stage register
    typedef struct packed {
        logic                    valid;
        logic                    uncond;
        logic [PHT_MAX_BITS-1:0] index;
        logic                    backward;
        logic                    predicted;
        logic                    taken;
    } resolve_t;

endpackage

`default_nettype wire
